// File: flist.f
+incdir+rtl
rtl/sched_geom_pkg.sv
rtl/sched_ctrl_pkg.sv
rtl/tile_geometry.sv
rtl/tile_loop_fsm.sv
rtl/tile_perf_counters.sv
rtl/gemm_tile_sched.sv
testbench/gemm_tile_sched_chk.sv
testbench/gemm_tile_sched_tb.sv

// File: testbench/gemm_tile_sched_tb.sv
// Testbench for the GEMM tile scheduler, random problems checked against a tile-walk model
`timescale 1ns/1ps
`include "sched_cfg.svh"

module gemm_tile_sched_tb;
  import sched_geom_pkg::*;
  import sched_ctrl_pkg::*;

  logic                     clk;
  logic                     rst_n;
  logic                     start;
  logic                     abort;
  gemm_dims_t               dims;
  bank_valid_t              bank_valid;
  buf_ctrl_t                buf_ctrl;
  logic [`SCHED_MAX_TM-1:0] en_mask_row;
  logic [`SCHED_MAX_TN-1:0] en_mask_col;
  logic                     busy;
  logic                     done_tile;
  tile_idx_t                tile_idx;
  logic [`SCHED_CNT_W-1:0]  cycles_tile;
  logic [`SCHED_CNT_W-1:0]  stall_cycles;

  // Model state
  gemm_dims_t  run_dims;
  logic [15:0] lfsr;
  logic        monitor_on;
  logic        prev_rd;
  logic        clr_ping;
  logic        clr_pong;
  logic        saw_stream;
  int          mt, nt, kt;
  int          exp_m, exp_n, exp_k, tm_eff, tn_eff, exp_tk;
  int          rd_cnt, en_cnt, stall_cnt, tiles_done, wait_cycles;

  // 16-bit Galois LFSR, one step per bit taken
  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic int ceil_div(input int a, input int b);
    return (a + b - 1) / b;
  endfunction

  // Edge tiles only get what is left of the dimension
  function automatic int eff_size(input int dim, input int tile, input int pos);
    return (dim - pos * tile < tile) ? dim - pos * tile : tile;
  endfunction

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic value_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic timeout_error(input string msg);
    $display("Timed out: %s", msg);
    stop_run();
  endtask

  always #2 clk = ~clk;

  gemm_tile_sched gemm_tile_sched_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .abort        (abort),
    .dims         (dims),
    .bank_valid   (bank_valid),
    .buf_ctrl     (buf_ctrl),
    .en_mask_row  (en_mask_row),
    .en_mask_col  (en_mask_col),
    .busy         (busy),
    .done_tile    (done_tile),
    .tile_idx     (tile_idx),
    .cycles_tile  (cycles_tile),
    .stall_cycles (stall_cycles)
  );

  // ------------------------------
  // DMA stand-in
  // ------------------------------
  // Banks fill at random and are freed once their slice has drained
  always @(posedge clk) begin
    if (rst_n) begin
      if (clr_ping) begin
        bank_valid.a_ping <= 1'b0;
        bank_valid.b_ping <= 1'b0;
        clr_ping = 1'b0;
      end else begin
        bank_valid.a_ping <= bank_valid.a_ping | take_bits(1);
        bank_valid.b_ping <= bank_valid.b_ping | take_bits(1);
      end
      if (clr_pong) begin
        bank_valid.a_pong <= 1'b0;
        bank_valid.b_pong <= 1'b0;
        clr_pong = 1'b0;
      end else begin
        bank_valid.a_pong <= bank_valid.a_pong | take_bits(1);
        bank_valid.b_pong <= bank_valid.b_pong | take_bits(1);
      end
    end
  end

  // ------------------------------
  // Monitor and tile-walk model
  // ------------------------------
  // Samples on the falling edge, away from the driving edge
  always @(negedge clk) begin
    if (rst_n && monitor_on) begin
      if (buf_ctrl.clr) begin
        exp_k     = 0;
        rd_cnt    = 0;
        en_cnt    = 0;
        stall_cnt = 0;
      end
      if (buf_ctrl.rd_en) begin
        // Abort point, only once the walk has moved off the origin
        if (tile_idx != '0) begin
          saw_stream = 1'b1;
        end
        assert (buf_ctrl.bank_sel == exp_k[0] && tile_idx.k_tile == exp_k)
          else value_error($sformatf("k_tile %0d, expected %0d", tile_idx.k_tile, exp_k));
        assert (buf_ctrl.k_idx == rd_cnt)
          else value_error($sformatf("k_idx %0d, expected %0d", buf_ctrl.k_idx, rd_cnt));
        assert (buf_ctrl.bank_sel ? (bank_valid.a_pong && bank_valid.b_pong)
                                  : (bank_valid.a_ping && bank_valid.b_ping))
          else value_error("read issued from a bank that is not valid");
        rd_cnt++;
      end
      // Compute trails the read by exactly one cycle
      assert (buf_ctrl.en == prev_rd) else value_error("en does not trail rd_en");
      if (buf_ctrl.en) begin
        en_cnt++;
      end
      // Drain cycle closes the slice
      if (buf_ctrl.en && !buf_ctrl.rd_en) begin
        exp_tk = eff_size(dims.k, dims.tk, exp_k);
        assert (rd_cnt == exp_tk && en_cnt == exp_tk)
          else value_error($sformatf("slice of %0d/%0d steps, expected %0d",
                                     rd_cnt, en_cnt, exp_tk));
        if (buf_ctrl.bank_sel) begin
          clr_pong = 1'b1;
        end else begin
          clr_ping = 1'b1;
        end
        exp_k++;
        rd_cnt = 0;
        en_cnt = 0;
      end
      if (busy && !buf_ctrl.clr && !buf_ctrl.rd_en && !buf_ctrl.en && !done_tile) begin
        stall_cnt++;
      end
      if (done_tile) begin
        tm_eff = eff_size(dims.m, dims.tm, exp_m);
        tn_eff = eff_size(dims.n, dims.tn, exp_n);
        assert (tile_idx.m_tile == exp_m && tile_idx.n_tile == exp_n && exp_k == kt)
          else value_error($sformatf("tile (%0d,%0d) done, expected (%0d,%0d)",
                                     tile_idx.m_tile, tile_idx.n_tile, exp_m, exp_n));
        assert (en_mask_row == (64'd1 << tm_eff) - 64'd1 &&
                en_mask_col == (64'd1 << tn_eff) - 64'd1)
          else value_error("edge masks do not match tile size");
        assert (cycles_tile == dims.k + kt)
          else value_error($sformatf("cycles_tile %0d, expected %0d", cycles_tile, dims.k + kt));
        assert (stall_cycles == stall_cnt)
          else value_error($sformatf("stall_cycles %0d, expected %0d", stall_cycles, stall_cnt));
        tiles_done++;
        // n runs fastest
        if (exp_n + 1 < nt) begin
          exp_n++;
        end else begin
          exp_n = 0;
          exp_m++;
        end
      end
      prev_rd = buf_ctrl.rd_en;
    end
  end

  // ------------------------------
  // Run sequence
  // ------------------------------
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    start      = 1'b0;
    abort      = 1'b0;
    dims       = '0;
    bank_valid = '0;
    lfsr       = 16'd90;
    monitor_on = 1'b0;
    prev_rd    = 1'b0;
    clr_ping   = 1'b0;
    clr_pong   = 1'b0;
    saw_stream = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int run = 0; run < 12; run++) begin
      // Problem drawn away from the edge where the DMA stand-in draws
      run_dims.m  = 1 + take_bits(6) % 40;
      run_dims.n  = 1 + take_bits(6) % 40;
      run_dims.k  = 1 + take_bits(6) % 40;
      run_dims.tm = 1 + take_bits(3);
      run_dims.tn = 1 + take_bits(3);
      run_dims.tk = 1 + take_bits(3);
      // Abort run needs at least a second k-slice
      if (run == 6 && run_dims.k <= run_dims.tk) begin
        run_dims.k = run_dims.tk + 1;
      end
      @(posedge clk);
      mt          = ceil_div(run_dims.m, run_dims.tm);
      nt          = ceil_div(run_dims.n, run_dims.tn);
      kt          = ceil_div(run_dims.k, run_dims.tk);
      exp_m       = 0;
      exp_n       = 0;
      tiles_done  = 0;
      prev_rd     = 1'b0;
      saw_stream  = 1'b0;
      monitor_on  = 1'b1;
      dims  <= run_dims;
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      wait_cycles = 0;
      if (run == 6) begin
        // Abort in the middle of a k-slice
        while (!saw_stream) begin
          @(posedge clk);
          wait_cycles++;
          if (wait_cycles > 5000) timeout_error("no later k-slice started before abort");
        end
        abort <= 1'b1;
        monitor_on = 1'b0;
        @(posedge clk);
        abort <= 1'b0;
        @(negedge clk);
        assert (!busy && tile_idx == '0) else value_error("abort did not return to idle");
      end else begin
        while (tiles_done < mt * nt) begin
          @(posedge clk);
          wait_cycles++;
          if (wait_cycles > 2000000) timeout_error("tile walk did not finish");
        end
        @(negedge clk);
        assert (!busy) else value_error("busy still high after the last tile");
      end
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: testbench/gemm_tile_sched_chk.sv
// Protocol checker for the GEMM tile scheduler outputs, bound into the top level
`timescale 1ns/1ps

module gemm_tile_sched_chk (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        start,
  input logic                        abort,
  input logic                        busy,
  input logic                        done_tile,
  input sched_geom_pkg::gemm_dims_t  dims,
  input sched_ctrl_pkg::bank_valid_t bank_valid,
  input sched_ctrl_pkg::buf_ctrl_t   buf_ctrl
);
  import sched_geom_pkg::*;
  import sched_ctrl_pkg::*;

  // Both operand banks picked by bank_sel are loaded
  logic sel_ready;
  assign sel_ready = buf_ctrl.bank_sel ? (bank_valid.a_pong && bank_valid.b_pong)
                                       : (bank_valid.a_ping && bank_valid.b_ping);

  clr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    buf_ctrl.clr |=> !buf_ctrl.clr) else $error("clr held longer than one cycle");

  // en continues a run that a read started
  en_after_rd: assert property (@(posedge clk) disable iff (!rst_n)
    buf_ctrl.en |-> ($past(buf_ctrl.rd_en) || $past(buf_ctrl.en)))
    else $error("en raised without a preceding read");

  rd_ready: assert property (@(posedge clk) disable iff (!rst_n)
    buf_ctrl.rd_en |-> sel_ready) else $error("read while selected banks not valid");

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_tile |=> !done_tile) else $error("done_tile held longer than one cycle");

  // Start is only taken in idle or done
  dims_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    (start && !busy && !abort) |->
      (dims.m != 0 && dims.n != 0 && dims.k != 0 &&
       dims.tm != 0 && dims.tn != 0 && dims.tk != 0))
    else $error("start accepted with a zero dimension");

endmodule

bind gemm_tile_sched gemm_tile_sched_chk gemm_tile_sched_chk_inst (
  .clk        (clk),
  .rst_n      (rst_n),
  .start      (start),
  .abort      (abort),
  .busy       (busy),
  .done_tile  (done_tile),
  .dims       (dims),
  .bank_valid (bank_valid),
  .buf_ctrl   (buf_ctrl)
);

// File: rtl/gemm_tile_sched.sv
// GEMM tile scheduler top: geometry, loop-nest FSM and perf counters
`timescale 1ns/1ps
`include "sched_cfg.svh"

module gemm_tile_sched (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic                         abort,
  input  sched_geom_pkg::gemm_dims_t   dims,
  input  sched_ctrl_pkg::bank_valid_t  bank_valid,
  output sched_ctrl_pkg::buf_ctrl_t    buf_ctrl,
  output logic [`SCHED_MAX_TM-1:0]     en_mask_row,
  output logic [`SCHED_MAX_TN-1:0]     en_mask_col,
  output logic                         busy,
  output logic                         done_tile,
  output sched_geom_pkg::tile_idx_t    tile_idx,
  output logic [`SCHED_CNT_W-1:0]      cycles_tile,
  output logic [`SCHED_CNT_W-1:0]      stall_cycles
);
  import sched_geom_pkg::*;
  import sched_ctrl_pkg::*;

  tile_counts_t counts;
  tile_eff_t    eff;
  sched_phase_t phase;

  // Combinational, follows tile_idx with no delay
  tile_geometry tile_geometry_inst (
    .dims        (dims),
    .idx         (tile_idx),
    .counts      (counts),
    .eff         (eff),
    .en_mask_row (en_mask_row),
    .en_mask_col (en_mask_col)
  );

  tile_loop_fsm tile_loop_fsm_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .abort      (abort),
    .bank_valid (bank_valid),
    .counts     (counts),
    .tk_eff     (eff.tk_eff),
    .buf_ctrl   (buf_ctrl),
    .idx        (tile_idx),
    .phase      (phase),
    .busy       (busy),
    .done_tile  (done_tile)
  );

  // Counters only watch the FSM phase
  tile_perf_counters tile_perf_counters_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .phase        (phase),
    .cycles_tile  (cycles_tile),
    .stall_cycles (stall_cycles)
  );

endmodule

// File: rtl/tile_perf_counters.sv
// Per-tile perf counters: compute cycles and bank-wait stall cycles
`timescale 1ns/1ps
`include "sched_cfg.svh"

module tile_perf_counters (
  input  logic                         clk,
  input  logic                         rst_n,
  input  sched_ctrl_pkg::sched_phase_t phase,
  output logic [`SCHED_CNT_W-1:0]      cycles_tile,
  output logic [`SCHED_CNT_W-1:0]      stall_cycles
);
  import sched_ctrl_pkg::*;

  // ------------------------------
  // Counters
  // ------------------------------
  // Cleared on prep_tile, counts land one cycle after the phase
  // Both stick at all-ones instead of wrapping
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycles_tile  <= '0;
      stall_cycles <= '0;
    end else if (phase == ph_prep_tile) begin
      cycles_tile  <= '0;
      stall_cycles <= '0;
    end else if (phase == ph_stream_k) begin
      // Bubble and drain cycles included, so a tile totals k + kt
      if (cycles_tile != '1) begin
        cycles_tile <= cycles_tile + 1'b1;
      end
    end else if (phase == ph_wait_ready) begin
      // Waiting on ping/pong banks
      if (stall_cycles != '1) begin
        stall_cycles <= stall_cycles + 1'b1;
      end
    end
  end

endmodule

// File: rtl/tile_loop_fsm.sv
// Loop-nest FSM: walks (m, n, k) tiles, picks ping/pong banks and streams each k-slice
`timescale 1ns/1ps
`include "sched_cfg.svh"

module tile_loop_fsm (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic                         abort,
  input  sched_ctrl_pkg::bank_valid_t  bank_valid,
  input  sched_geom_pkg::tile_counts_t counts,
  input  logic [`SCHED_TK_W-1:0]       tk_eff,
  output sched_ctrl_pkg::buf_ctrl_t    buf_ctrl,
  output sched_geom_pkg::tile_idx_t    idx,
  output sched_ctrl_pkg::sched_phase_t phase,
  output logic                         busy,
  output logic                         done_tile
);
  import sched_geom_pkg::*;
  import sched_ctrl_pkg::*;

  sched_phase_t           state;
  sched_phase_t           state_nxt;
  tile_idx_t              idx_q;
  // Step inside the k-slice, runs 0..tk_eff
  logic [`SCHED_TK_W-1:0] k_ctr;
  logic                   bank_sel;
  logic                   banks_ready;
  logic                   slice_end;
  logic                   last_slice;
  logic                   last_tile;

  // ------------------------------
  // Bank policy and loop bounds
  // ------------------------------
  // Even k_tile reads ping, odd reads pong, same bank for A and B
  assign bank_sel    = idx_q.k_tile[0];
  assign banks_ready = bank_sel ? (bank_valid.a_pong && bank_valid.b_pong)
                                : (bank_valid.a_ping && bank_valid.b_ping);

  // Last stream cycle only computes, the read was issued one cycle earlier
  assign slice_end  = (k_ctr == tk_eff);
  assign last_slice = (idx_q.k_tile + 1 >= counts.kt);
  assign last_tile  = (idx_q.n_tile + 1 >= counts.nt) && (idx_q.m_tile + 1 >= counts.mt);

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      ph_idle, ph_done: begin
        if (start) begin
          state_nxt = ph_prep_tile;
        end
      end
      ph_prep_tile: state_nxt = ph_wait_ready;
      // Back-pressure, hold until both operand banks are loaded
      ph_wait_ready: begin
        if (banks_ready) begin
          state_nxt = ph_stream_k;
        end
      end
      ph_stream_k: begin
        if (slice_end) begin
          state_nxt = last_slice ? ph_tile_done : ph_wait_ready;
        end
      end
      ph_tile_done: state_nxt = last_tile ? ph_done : ph_prep_tile;
      default:      state_nxt = ph_idle;
    endcase
    // Abort beats everything
    if (abort) begin
      state_nxt = ph_idle;
    end
  end

  // ------------------------------
  // State, indices and k counter
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ph_idle;
      idx_q <= '0;
      k_ctr <= '0;
    end else begin
      state <= state_nxt;
      if (abort) begin
        idx_q <= '0;
        k_ctr <= '0;
      end else begin
        case (state)
          // New (m, n) tile always starts from k_tile 0
          ph_prep_tile: begin
            idx_q.k_tile <= '0;
            k_ctr        <= '0;
          end
          ph_stream_k: begin
            if (slice_end) begin
              k_ctr <= '0;
              // k_tile stays put on the final slice so tile_done still shows it
              if (!last_slice) begin
                idx_q.k_tile <= idx_q.k_tile + 1'b1;
              end
            end else begin
              k_ctr <= k_ctr + 1'b1;
            end
          end
          // n runs fastest, m wraps after the last n tile
          ph_tile_done: begin
            idx_q.k_tile <= '0;
            if (last_tile) begin
              idx_q.m_tile <= '0;
              idx_q.n_tile <= '0;
            end else if (idx_q.n_tile + 1 < counts.nt) begin
              idx_q.n_tile <= idx_q.n_tile + 1'b1;
            end else begin
              idx_q.n_tile <= '0;
              idx_q.m_tile <= idx_q.m_tile + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  // First stream cycle is the read bubble, en trails rd_en by one cycle
  always_comb begin
    buf_ctrl.rd_en    = (state == ph_stream_k) && (k_ctr < tk_eff);
    buf_ctrl.k_idx    = (state == ph_stream_k) ? k_ctr : '0;
    buf_ctrl.bank_sel = bank_sel;
    buf_ctrl.clr      = (state == ph_prep_tile);
    buf_ctrl.en       = (state == ph_stream_k) && (k_ctr != '0);
  end

  assign busy      = (state != ph_idle) && (state != ph_done);
  assign done_tile = (state == ph_tile_done);
  assign phase     = state;
  assign idx       = idx_q;

endmodule

// File: rtl/tile_geometry.sv
// Tile geometry: ceiling-division tile counts, edge-tile sizes and PE enable masks
`timescale 1ns/1ps
`include "sched_cfg.svh"

module tile_geometry (
  input  sched_geom_pkg::gemm_dims_t   dims,
  input  sched_geom_pkg::tile_idx_t    idx,
  output sched_geom_pkg::tile_counts_t counts,
  output sched_geom_pkg::tile_eff_t    eff,
  output logic [`SCHED_MAX_TM-1:0]     en_mask_row,
  output logic [`SCHED_MAX_TN-1:0]     en_mask_col
);

  // dim + tile - 1, one guard bit so it cannot wrap
  logic [`SCHED_M_W:0] m_sum;
  logic [`SCHED_N_W:0] n_sum;
  logic [`SCHED_K_W:0] k_sum;

  // Start of the current tile inside the full dimension
  logic [`SCHED_M_W+`SCHED_TM_W-1:0] m_off;
  logic [`SCHED_N_W+`SCHED_TN_W-1:0] n_off;
  logic [`SCHED_K_W+`SCHED_TK_W-1:0] k_off;

  // What is left of the dimension from that offset on
  logic [`SCHED_M_W-1:0] m_rem;
  logic [`SCHED_N_W-1:0] n_rem;
  logic [`SCHED_K_W-1:0] k_rem;

  // ------------------------------
  // Tile counts
  // ------------------------------
  // Zero tile size gives zero tiles, only seen while idle
  always_comb begin
    m_sum     = dims.m + dims.tm - 1'b1;
    n_sum     = dims.n + dims.tn - 1'b1;
    k_sum     = dims.k + dims.tk - 1'b1;
    counts.mt = (dims.tm == '0) ? '0 : `SCHED_M_W'(m_sum / dims.tm);
    counts.nt = (dims.tn == '0) ? '0 : `SCHED_N_W'(n_sum / dims.tn);
    counts.kt = (dims.tk == '0) ? '0 : `SCHED_K_W'(k_sum / dims.tk);
  end

  // ------------------------------
  // Effective sizes
  // ------------------------------
  always_comb begin
    m_off = idx.m_tile * dims.tm;
    n_off = idx.n_tile * dims.tn;
    k_off = idx.k_tile * dims.tk;
    // Offset is always below dim on a legal walk, clamp anyway
    m_rem = (dims.m > m_off) ? dims.m - m_off[`SCHED_M_W-1:0] : '0;
    n_rem = (dims.n > n_off) ? dims.n - n_off[`SCHED_N_W-1:0] : '0;
    k_rem = (dims.k > k_off) ? dims.k - k_off[`SCHED_K_W-1:0] : '0;
    // Full tile unless the remainder is shorter
    eff.tm_eff = (m_rem > dims.tm) ? dims.tm : m_rem[`SCHED_TM_W-1:0];
    eff.tn_eff = (n_rem > dims.tn) ? dims.tn : n_rem[`SCHED_TN_W-1:0];
    eff.tk_eff = (k_rem > dims.tk) ? dims.tk : k_rem[`SCHED_TK_W-1:0];
  end

  // ------------------------------
  // Edge masks
  // ------------------------------
  // Thermometer code, bit i set for PE row/col i inside the tile
  always_comb begin
    for (int i = 0; i < `SCHED_MAX_TM; i++) begin
      en_mask_row[i] = (i < eff.tm_eff);
    end
    for (int j = 0; j < `SCHED_MAX_TN; j++) begin
      en_mask_col[j] = (j < eff.tn_eff);
    end
  end

endmodule

// File: rtl/sched_ctrl_pkg.sv
// Control and status types: bank readiness, buffer/array strobes, scheduler phase
`include "sched_cfg.svh"

package sched_ctrl_pkg;

  // ------------------------------
  // Inputs from host / DMA
  // ------------------------------
  // Level per bank, set once that bank holds the needed k-slice
  typedef struct packed {
    logic a_ping;
    logic a_pong;
    logic b_ping;
    logic b_pong;
  } bank_valid_t;

  // ------------------------------
  // Outputs to buffers and array
  // ------------------------------
  // rd_en and k_idx go to both operand buffers
  // bank_sel is shared by A and B, 0 = ping, 1 = pong
  // clr zeroes the accumulators at tile start
  // en is the MAC enable, one cycle behind rd_en
  typedef struct packed {
    logic                   rd_en;
    logic [`SCHED_TK_W-1:0] k_idx;
    logic                   bank_sel;
    logic                   clr;
    logic                   en;
  } buf_ctrl_t;

  // Loop-nest FSM states, also exported to the perf counters
  typedef enum logic [2:0] {
    ph_idle,
    ph_prep_tile,
    ph_wait_ready,
    ph_stream_k,
    ph_tile_done,
    ph_done
  } sched_phase_t;

endpackage

// File: rtl/sched_geom_pkg.sv
// Geometry types: problem dims, tile counts, tile coordinates and edge-tile sizes
`include "sched_cfg.svh"

package sched_geom_pkg;

  // ------------------------------
  // Problem description
  // ------------------------------
  // Full GEMM dims and tile dims
  // Host keeps these stable while the scheduler is busy
  typedef struct packed {
    logic [`SCHED_M_W-1:0]  m;
    logic [`SCHED_N_W-1:0]  n;
    logic [`SCHED_K_W-1:0]  k;
    logic [`SCHED_TM_W-1:0] tm;
    logic [`SCHED_TN_W-1:0] tn;
    logic [`SCHED_TK_W-1:0] tk;
  } gemm_dims_t;

  // Number of tiles per dimension, ceil(dim / tile)
  typedef struct packed {
    logic [`SCHED_M_W-1:0] mt;
    logic [`SCHED_N_W-1:0] nt;
    logic [`SCHED_K_W-1:0] kt;
  } tile_counts_t;

  // ------------------------------
  // Walk position
  // ------------------------------
  // Coordinates of the tile being worked on
  typedef struct packed {
    logic [`SCHED_M_W-1:0] m_tile;
    logic [`SCHED_N_W-1:0] n_tile;
    logic [`SCHED_K_W-1:0] k_tile;
  } tile_idx_t;

  // Effective sizes, smaller than the tile size only on edge tiles
  typedef struct packed {
    logic [`SCHED_TM_W-1:0] tm_eff;
    logic [`SCHED_TN_W-1:0] tn_eff;
    logic [`SCHED_TK_W-1:0] tk_eff;
  } tile_eff_t;

endpackage

// File: rtl/sched_cfg.svh
// Scheduler configuration: problem, tile, PE-array and counter widths
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// ------------------------------
// Problem dimensions and tile indices
// ------------------------------
`define SCHED_M_W 10
`define SCHED_N_W 10
// K is usually the deepest dimension
`define SCHED_K_W 12

// ------------------------------
// Tile dimensions and PE array
// ------------------------------
`define SCHED_TM_W 6
`define SCHED_TN_W 6
`define SCHED_TK_W 6
// One mask bit per PE row and column
`define SCHED_MAX_TM (1 << `SCHED_TM_W)
`define SCHED_MAX_TN (1 << `SCHED_TN_W)

// Per-tile perf counter width
`define SCHED_CNT_W 32
`endif
